/* common/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

////////////////////
// Opcodes
////////////////////

`define MEM_OP_LOAD   7'b0000011
`define MEM_OP_STORE  7'b0100011

////////////////////
// Access sizes
////////////////////

`define MEM_F3_B   3'b000
`define MEM_F3_H   3'b001
`define MEM_F3_W   3'b010
`define MEM_F3_BU  3'b100
`define MEM_F3_HU  3'b101

// Data RAM depth in 32-bit words.
`define MEM_WORDS  256

`endif

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    ////////////////////
    // Instruction word
    ////////////////////

    // Load layout.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Store layout.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } rv_instr_u;

    ////////////////////
    // Memory bus
    ////////////////////

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;   // Always word aligned.
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        ack;    // One-cycle pulse.
        logic [31:0] rdata;
    } bus_rsp_t;

    // Completion record of one load or store.
    typedef struct packed {
        logic [4:0]  rd;
        logic        is_load;
        logic [31:0] data;
    } mem_result_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/mem_pkg.sv
design/word_ram.sv
design/bus_arbiter.sv
design/fetch_unit.sv
mem_stage/mem_stage.sv
design/lsu_top.sv
tests/lsu_sva.sv
tests/lsu_tb.sv

/* design/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic              clk,
    input  logic              rst_i,
    input  mem_pkg::bus_req_t data_req_i,
    output mem_pkg::bus_rsp_t data_rsp_o,
    input  mem_pkg::bus_req_t fetch_req_i,
    output mem_pkg::bus_rsp_t fetch_rsp_o,
    output mem_pkg::bus_req_t ram_req_o,
    input  mem_pkg::bus_rsp_t ram_rsp_i
);

    import mem_pkg::*;

    logic     owner_q;  // High when fetch owns the bus.
    logic     locked_q;
    logic     data_act, fetch_act;
    logic     grant_fetch;
    bus_req_t grant_req;

    assign data_act  = data_req_i.read | data_req_i.write;
    assign fetch_act = fetch_req_i.read | fetch_req_i.write;

    // Data wins a free bus.
    always_comb begin
        if (locked_q) begin
            grant_fetch = owner_q;
        end else begin
            grant_fetch = !data_act && fetch_act;
        end
    end

    assign grant_req = grant_fetch ? fetch_req_i : data_req_i;
    assign ram_req_o = grant_req;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            owner_q  <= 1'b0;
            locked_q <= 1'b0;
        end else if (locked_q) begin
            if (ram_rsp_i.ack) begin
                locked_q <= 1'b0; // Release on ack.
            end
        end else if (data_act || fetch_act) begin
            locked_q <= 1'b1;
            owner_q  <= grant_fetch;
        end
    end

    assign data_rsp_o.ack    = ram_rsp_i.ack && locked_q && !owner_q;
    assign data_rsp_o.rdata  = ram_rsp_i.rdata;
    assign fetch_rsp_o.ack   = ram_rsp_i.ack && locked_q && owner_q;
    assign fetch_rsp_o.rdata = ram_rsp_i.rdata;

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              fetch_req_i,
    input  logic [31:0]       fetch_pc_i,
    output logic              fetch_busy_o,
    output logic              fetch_valid_o,
    output logic [31:0]       fetch_data_o,
    output mem_pkg::bus_req_t bus_req_o,
    input  mem_pkg::bus_rsp_t bus_rsp_i
);

    logic        busy_q;
    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] data_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (busy_q) begin
                if (bus_rsp_i.ack) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end else if (fetch_req_i) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && fetch_req_i) begin
            pc_q <= {fetch_pc_i[31:2], 2'b00}; // Word fetch only.
        end
        if (busy_q && bus_rsp_i.ack) begin
            data_q <= bus_rsp_i.rdata;
        end
    end

    // Read held until its ack.
    assign bus_req_o.read  = busy_q;
    assign bus_req_o.write = 1'b0;
    assign bus_req_o.addr  = pc_q;
    assign bus_req_o.wdata = 32'd0;

    assign fetch_busy_o  = busy_q;
    assign fetch_valid_o = valid_q;
    assign fetch_data_o  = data_q;

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 op_valid_i,
    input  mem_pkg::rv_instr_u   instr_i,
    input  logic [31:0]          addr_i,
    input  logic [31:0]          store_data_i,
    output logic                 busy_o,
    output logic                 done_o,
    output mem_pkg::mem_result_t result_o,
    input  logic                 fetch_req_i,
    input  logic [31:0]          fetch_pc_i,
    output logic                 fetch_busy_o,
    output logic                 fetch_valid_o,
    output logic [31:0]          fetch_data_o
);

    import mem_pkg::*;

    bus_req_t data_req, fetch_bus_req, ram_req;
    bus_rsp_t data_rsp, fetch_bus_rsp, ram_rsp;

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_valid_i   (op_valid_i),
        .instr_i      (instr_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .result_o     (result_o),
        .bus_req_o    (data_req),
        .bus_rsp_i    (data_rsp)
    );

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_busy_o  (fetch_busy_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .bus_req_o     (fetch_bus_req),
        .bus_rsp_i     (fetch_bus_rsp)
    );

    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .rst_i       (rst_i),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .fetch_req_i (fetch_bus_req),
        .fetch_rsp_o (fetch_bus_rsp),
        .ram_req_o   (ram_req),
        .ram_rsp_i   (ram_rsp)
    );

    word_ram u_word_ram (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

endmodule

`default_nettype wire

/* design/word_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module word_ram (
    input  logic              clk,
    input  logic              rst_i,
    input  mem_pkg::bus_req_t req_i,
    output mem_pkg::bus_rsp_t rsp_o
);

    localparam int AW = $clog2(`MEM_WORDS);

    logic [31:0]   mem [`MEM_WORDS];
    logic [AW-1:0] idx;
    logic          ack_q;
    logic [31:0]   rdata_q;

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = 32'd0;
        end
    end

    assign idx = req_i.addr[AW+1:2]; // Wraps at the depth.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= (req_i.read || req_i.write) && !ack_q;
        end
    end

    // Request seen during an ack cycle is the one just answered.
    always_ff @(posedge clk) begin
        if (req_i.write && !ack_q) begin
            mem[idx] <= req_i.wdata;
        end
        if (req_i.read && !ack_q) begin
            rdata_q <= mem[idx];
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

/* mem_stage/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 op_valid_i,
    input  mem_pkg::rv_instr_u   instr_i,
    input  logic [31:0]          addr_i,
    input  logic [31:0]          store_data_i,
    output logic                 busy_o,
    output logic                 done_o,
    output mem_pkg::mem_result_t result_o,
    output mem_pkg::bus_req_t    bus_req_o,
    input  mem_pkg::bus_rsp_t    bus_rsp_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD0,
        ST_WR0,
        ST_RD1,
        ST_WR1
    } state_t;

    state_t      state_q, state_d;
    logic        in_load, in_store, accept, finish, second;
    logic [2:0]  in_f3;

    logic        is_load_q, cross_q;
    logic [2:0]  f3_q;
    logic [4:0]  rd_q;
    logic [1:0]  off_q;
    logic [29:0] wa_q;
    logic [31:0] sdata_q, word0_q, word1_q;

    logic [7:0]  be8;
    logic [63:0] sh_data, ld_shift;
    logic [31:0] m_lo, m_hi, st_lo, st_hi, ld_lo;

    // Byte enables to bit mask.
    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    function automatic logic [3:0] size_be(input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return 4'b0001;
            2'b01:   return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // True when the access spills into the next word.
    function automatic logic crosses(input logic [2:0] f3, input logic [1:0] off);
        case (f3[1:0])
            2'b01:   return off == 2'b11;
            2'b10:   return off != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] extend(input logic [2:0] f3, input logic [31:0] w);
        case (f3)
            `MEM_F3_B:  return {{24{w[7]}}, w[7:0]};
            `MEM_F3_H:  return {{16{w[15]}}, w[15:0]};
            `MEM_F3_BU: return {24'd0, w[7:0]};
            `MEM_F3_HU: return {16'd0, w[15:0]};
            default:    return w;
        endcase
    endfunction

    ////////////////////
    // Decode
    ////////////////////

    assign in_load  = instr_i.i_fmt.opcode == `MEM_OP_LOAD;
    assign in_store = instr_i.s_fmt.opcode == `MEM_OP_STORE;
    assign in_f3    = instr_i.i_fmt.funct3; // Same bits in both layouts.
    assign accept   = op_valid_i && !busy_o && (in_load || in_store);

    ////////////////////
    // Sequencer
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    // Full aligned word stores skip the read.
                    if (in_store && in_f3 == `MEM_F3_W && addr_i[1:0] == 2'b00) begin
                        state_d = ST_WR0;
                    end else begin
                        state_d = ST_RD0;
                    end
                end
            end
            ST_RD0: begin
                if (bus_rsp_i.ack) begin
                    if (!is_load_q) begin
                        state_d = ST_WR0;
                    end else begin
                        state_d = cross_q ? ST_RD1 : ST_IDLE;
                    end
                end
            end
            ST_WR0: begin
                if (bus_rsp_i.ack) begin
                    state_d = cross_q ? ST_RD1 : ST_IDLE;
                end
            end
            ST_RD1: begin
                if (bus_rsp_i.ack) begin
                    state_d = is_load_q ? ST_IDLE : ST_WR1;
                end
            end
            ST_WR1: begin
                if (bus_rsp_i.ack) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    assign finish = (state_q != ST_IDLE) && (state_d == ST_IDLE);
    assign busy_o = state_q != ST_IDLE;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_load_q <= in_load;
            f3_q      <= in_f3;
            rd_q      <= in_load ? instr_i.i_fmt.rd : 5'd0; // Stores report x0.
            off_q     <= addr_i[1:0];
            wa_q      <= addr_i[31:2];
            sdata_q   <= store_data_i;
            cross_q   <= crosses(in_f3, addr_i[1:0]);
        end
        if (bus_rsp_i.ack && state_q == ST_RD0) begin
            word0_q <= bus_rsp_i.rdata;
        end
        if (bus_rsp_i.ack && state_q == ST_RD1) begin
            word1_q <= bus_rsp_i.rdata;
        end
        if (finish) begin
            result_o.rd      <= rd_q;
            result_o.is_load <= is_load_q;
            result_o.data    <= is_load_q ? extend(f3_q, ld_shift[31:0]) : 32'd0;
        end
    end

    ////////////////////
    // Data path
    ////////////////////

    // Store bytes placed across the two-word window.
    assign be8     = {4'd0, size_be(f3_q)} << off_q;
    assign sh_data = {32'd0, sdata_q} << {off_q, 3'b000};
    assign m_lo    = lane_mask(be8[3:0]);
    assign m_hi    = lane_mask(be8[7:4]);
    assign st_lo   = (word0_q & ~m_lo) | (sh_data[31:0] & m_lo);
    assign st_hi   = (word1_q & ~m_hi) | (sh_data[63:32] & m_hi);

    // Second word arrives live, first word from the register.
    assign ld_lo    = (state_q == ST_RD1) ? word0_q : bus_rsp_i.rdata;
    assign ld_shift = {bus_rsp_i.rdata, ld_lo} >> {off_q, 3'b000};

    assign second          = (state_q == ST_RD1) || (state_q == ST_WR1);
    assign bus_req_o.read  = (state_q == ST_RD0) || (state_q == ST_RD1);
    assign bus_req_o.write = (state_q == ST_WR0) || (state_q == ST_WR1);
    assign bus_req_o.addr  = {second ? wa_q + 30'd1 : wa_q, 2'b00};
    assign bus_req_o.wdata = second ? st_hi : st_lo;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module lsu_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    echo "Result: PASS"
    exit 0
fi

echo "Result: FAIL"
exit 1

/* tests/lsu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
    input logic              clk,
    input logic              rst_i,
    input mem_pkg::bus_req_t data_req_i,
    input mem_pkg::bus_rsp_t data_rsp_o,
    input mem_pkg::bus_req_t fetch_req_i,
    input mem_pkg::bus_rsp_t fetch_rsp_o,
    input mem_pkg::bus_req_t ram_req_o,
    input mem_pkg::bus_rsp_t ram_rsp_i
);

    int sva_errors = 0;

    rw_exclusive: assert property (@(posedge clk) disable iff (rst_i)
        !(data_req_i.read && data_req_i.write) && !(fetch_req_i.read && fetch_req_i.write)
        && !(ram_req_o.read && ram_req_o.write))
    else begin
        $error("read and write high together");
        sva_errors++;
    end

    // Write data only matters while writing.
    data_held: assert property (@(posedge clk) disable iff (rst_i)
        (data_req_i.read || data_req_i.write) && !data_rsp_o.ack |=>
            $stable(data_req_i.read) && $stable(data_req_i.write) && $stable(data_req_i.addr)
            && (!data_req_i.write || $stable(data_req_i.wdata)))
    else begin
        $error("data request changed before ack");
        sva_errors++;
    end

    fetch_held: assert property (@(posedge clk) disable iff (rst_i)
        fetch_req_i.read && !fetch_rsp_o.ack |=>
            $stable(fetch_req_i.read) && $stable(fetch_req_i.addr))
    else begin
        $error("fetch request changed before ack");
        sva_errors++;
    end

    one_ack: assert property (@(posedge clk) disable iff (rst_i)
        !(data_rsp_o.ack && fetch_rsp_o.ack))
    else begin
        $error("both peers saw ack");
        sva_errors++;
    end

    ram_aligned: assert property (@(posedge clk) disable iff (rst_i)
        (ram_req_o.read || ram_req_o.write) |-> ram_req_o.addr[1:0] == 2'b00)
    else begin
        $error("unaligned RAM request");
        sva_errors++;
    end

endmodule

bind bus_arbiter lsu_sva u_lsu_sva (.*);

`default_nettype wire

/* tests/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module lsu_tb;

    import mem_pkg::*;

    localparam int         TIMEOUT     = 200;
    localparam int         RANDOM_ROWS = 48;
    localparam logic [1:0] KIND_LOAD   = 2'd0;
    localparam logic [1:0] KIND_STORE  = 2'd1;
    localparam logic [1:0] KIND_FETCH  = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [31:0] fpc;
        logic [1:0]  fmode;  // 0 none, 1 same cycle, 2 while busy.
    } row_t;

    logic        clk, rst_i, op_valid_i, fetch_req_i;
    rv_instr_u   instr_i;
    logic [31:0] addr_i, store_data_i, fetch_pc_i;
    logic        busy_o, done_o, fetch_busy_o, fetch_valid_o;
    mem_result_t result_o;
    logic [31:0] fetch_data_o;

    row_t        rows[$];
    logic [7:0]  model [4*`MEM_WORDS];  // Byte image of the RAM.
    logic [31:0] lcg_state;
    int          checks, errors, rows_run;
    logic        timed_out;

    lsu_top DUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .op_valid_i    (op_valid_i),
        .instr_i       (instr_i),
        .addr_i        (addr_i),
        .store_data_i  (store_data_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .result_o      (result_o),
        .fetch_req_i   (fetch_req_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_busy_o  (fetch_busy_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int access_bytes(input logic [2:0] f3);
        case (f3)
            `MEM_F3_B, `MEM_F3_BU: return 1;
            `MEM_F3_H, `MEM_F3_HU: return 2;
            default:               return 4;
        endcase
    endfunction

    // Little endian, wraps at the top of memory.
    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] a);
        logic [31:0] raw;
        for (int i = 0; i < 4; i++) begin
            raw[i*8 +: 8] = model[a[9:0] + 10'(i)];
        end
        case (f3)
            `MEM_F3_B:  return 32'(signed'(raw[7:0]));
            `MEM_F3_H:  return 32'(signed'(raw[15:0]));
            `MEM_F3_BU: return 32'(raw[7:0]);
            `MEM_F3_HU: return 32'(raw[15:0]);
            default:    return raw;
        endcase
    endfunction

    task automatic model_store(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] d);
        for (int i = 0; i < access_bytes(f3); i++) begin
            model[a[9:0] + 10'(i)] = d[i*8 +: 8];
        end
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] pc);
        return model_load(`MEM_F3_W, {pc[31:2], 2'b00});
    endfunction

    ////////////////////
    // Stimulus table
    ////////////////////

    function automatic row_t make_row(input logic [1:0] kind, input logic [2:0] f3,
                                      input logic [31:0] a, input logic [31:0] d,
                                      input logic [31:0] pc, input logic [1:0] fm);
        row_t r;
        r.kind  = kind;
        r.f3    = f3;
        r.addr  = a;
        r.sdata = d;
        r.fpc   = pc;
        r.fmode = fm;
        return r;
    endfunction

    function automatic row_t random_row();
        row_t        r;
        logic [31:0] a, b, last;
        a = lcg_next();
        b = lcg_next();
        case (a[31:30])
            2'd0:    r.kind = KIND_STORE;
            2'd3:    r.kind = KIND_FETCH;
            default: r.kind = KIND_LOAD;
        endcase
        if (r.kind == KIND_STORE) begin
            case (a[25:24])
                2'd0:    r.f3 = `MEM_F3_B;
                2'd1:    r.f3 = `MEM_F3_H;
                default: r.f3 = `MEM_F3_W;
            endcase
        end else begin
            case (a[26:24])
                3'd0:    r.f3 = `MEM_F3_B;
                3'd1:    r.f3 = `MEM_F3_H;
                3'd3:    r.f3 = `MEM_F3_BU;
                3'd4:    r.f3 = `MEM_F3_HU;
                3'd5:    r.f3 = `MEM_F3_H;
                default: r.f3 = `MEM_F3_W;
            endcase
        end
        r.addr  = {22'd0, 2'b11, b[31:24]};  // Top 64 words, so some accesses wrap.
        r.fpc   = {22'd0, 2'b11, b[7:0]};
        r.sdata = lcg_next();
        r.fmode = (a[29:28] == 2'd3) ? 2'd0 : a[29:28];
        // Fetch of a word being stored has no single expected value.
        last = r.addr + 32'(access_bytes(r.f3) - 1);
        if (r.kind == KIND_STORE && r.fmode != 2'd0 &&
            (r.fpc[9:2] == r.addr[9:2] || r.fpc[9:2] == last[9:2])) begin
            r.fpc = {22'd0, r.addr[9:2] + 8'd2, 2'b00};
        end
        return r;
    endfunction

    task automatic build_table();
        rows.push_back(make_row(KIND_STORE, `MEM_F3_W,  32'h100, 32'hdead_beef, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h100, 32'h0, 32'h0, 2'd0));
        // Subword stores inside one word.
        rows.push_back(make_row(KIND_STORE, `MEM_F3_B,  32'h101, 32'h0000_00a5, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_STORE, `MEM_F3_H,  32'h106, 32'h0000_8001, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h100, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h104, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_B,  32'h101, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_BU, 32'h101, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_H,  32'h106, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_HU, 32'h106, 32'h0, 32'h0, 2'd0));
        // Accesses that cross a word boundary.
        rows.push_back(make_row(KIND_STORE, `MEM_F3_W,  32'h111, 32'h1122_3344, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h111, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h110, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h114, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_STORE, `MEM_F3_W,  32'h122, 32'hcafe_f00d, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h122, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_HU, 32'h123, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_STORE, `MEM_F3_H,  32'h12b, 32'h0000_beef, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_H,  32'h12b, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h128, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_STORE, `MEM_F3_W,  32'h133, 32'h89ab_cdef, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h130, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h134, 32'h0, 32'h0, 2'd0));
        // Fetches beside data traffic.
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h111, 32'h0, 32'h100, 2'd1));
        rows.push_back(make_row(KIND_STORE, `MEM_F3_W,  32'h140, 32'h0102_0304, 32'h113, 2'd2));
        rows.push_back(make_row(KIND_FETCH, `MEM_F3_W,  32'h0, 32'h0, 32'h142, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_H,  32'h12b, 32'h0, 32'h128, 2'd2));
        rows.push_back(make_row(KIND_STORE, `MEM_F3_B,  32'h104, 32'h0000_007e, 32'h130, 2'd1));
        // Wrap from the last word to word 0.
        rows.push_back(make_row(KIND_STORE, `MEM_F3_W,  32'h3fe, 32'h5566_7788, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_HU, 32'h3ff, 32'h0, 32'h0, 2'd0));
        rows.push_back(make_row(KIND_LOAD,  `MEM_F3_W,  32'h000, 32'h0, 32'h3fc, 2'd1));
        repeat (RANDOM_ROWS) begin
            rows.push_back(random_row());
        end
    endtask

    function automatic rv_instr_u make_instr(input row_t r, input logic [4:0] reg_no);
        rv_instr_u ins;
        if (r.kind == KIND_LOAD) begin
            ins.i_fmt.opcode = `MEM_OP_LOAD;
            ins.i_fmt.rd     = reg_no;
            ins.i_fmt.funct3 = r.f3;
            ins.i_fmt.rs1    = 5'd2;
            ins.i_fmt.imm    = r.addr[11:0];
        end else begin
            ins.s_fmt.opcode = `MEM_OP_STORE;
            ins.s_fmt.imm_lo = r.addr[4:0];
            ins.s_fmt.funct3 = r.f3;
            ins.s_fmt.rs1    = 5'd2;
            ins.s_fmt.rs2    = reg_no;
            ins.s_fmt.imm_hi = r.addr[11:5];
        end
        return ins;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            KIND_LOAD:  return "load";
            KIND_STORE: return "store";
            default:    return "fetch";
        endcase
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_result(input mem_result_t got, input mem_result_t exp);
        string gs, es;
        checks++;
        if (got !== exp) begin
            errors++;
            gs = $sformatf("rd=%0d load=%0b data=%h", got.rd, got.is_load, got.data);
            es = $sformatf("rd=%0d load=%0b data=%h", exp.rd, exp.is_load, exp.data);
            $display("CHECK FAILED at %0t: result %s, expected %s", $time, gs, es);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // Row sequencing
    ////////////////////

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((busy_o || fetch_busy_o) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy_o || fetch_busy_o) begin
            $display("Timeout: DUT still busy after %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_row(input int n, input row_t r);
        mem_result_t exp_res;
        logic [31:0] exp_word;
        logic [4:0]  reg_no;
        logic        got_done, got_fetch;
        int          cycles;
        int          errors_before;
        errors_before = errors;
        wait_idle();
        if (timed_out) begin
            return;
        end
        reg_no          = 5'(n % 31 + 1);
        exp_res.rd      = (r.kind == KIND_LOAD) ? reg_no : 5'd0;  // Stores report x0.
        exp_res.is_load = r.kind == KIND_LOAD;
        exp_res.data    = (r.kind == KIND_LOAD) ? model_load(r.f3, r.addr) : 32'd0;
        exp_word        = model_word(r.fpc);
        got_done        = r.kind == KIND_FETCH;
        got_fetch       = r.kind != KIND_FETCH && r.fmode == 2'd0;
        if (r.kind != KIND_FETCH) begin
            op_valid_i   = 1'b1;
            instr_i      = make_instr(r, reg_no);
            addr_i       = r.addr;
            store_data_i = r.sdata;
        end
        if (r.kind == KIND_FETCH || r.fmode == 2'd1) begin
            fetch_req_i = 1'b1;
            fetch_pc_i  = r.fpc;
        end
        if (r.kind == KIND_STORE) begin
            model_store(r.f3, r.addr, r.sdata);
        end
        @(posedge clk);
        #1;
        op_valid_i  = 1'b0;
        fetch_req_i = 1'b0;
        if (r.kind != KIND_FETCH && r.fmode == 2'd2) begin
            fetch_req_i = 1'b1;  // Stage is busy by now.
            fetch_pc_i  = r.fpc;
        end
        cycles = 0;
        while (!(got_done && got_fetch) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            fetch_req_i = 1'b0;
            if (done_o && !got_done) begin
                check_result(result_o, exp_res);
                got_done = 1'b1;
            end
            if (fetch_valid_o && !got_fetch) begin
                check_word("fetch word", fetch_data_o, exp_word);
                got_fetch = 1'b1;
            end
        end
        if (!(got_done && got_fetch)) begin
            $display("Timeout: row %0d saw no %s within %0d cycles", n,
                     got_done ? "fetch data" : "done pulse", TIMEOUT);
            timed_out = 1'b1;
        end
        rows_run++;
        $display("row %0d %s f3=%0d addr=%h fetch=%0d pc=%h: %s", n, kind_name(r.kind),
                 r.f3, r.addr, r.fmode, r.fpc,
                 (errors == errors_before && !timed_out) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_i        = 1'b1;
        op_valid_i   = 1'b0;
        instr_i      = '0;
        addr_i       = 32'd0;
        store_data_i = 32'd0;
        fetch_req_i  = 1'b0;
        fetch_pc_i   = 32'd0;
        checks       = 0;
        errors       = 0;
        rows_run     = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'hecf5_5320;
        for (int i = 0; i < 4*`MEM_WORDS; i++) begin
            model[i] = 8'h00;
        end
        build_table();

        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        check_flag("fetch_busy_o", fetch_busy_o, 1'b0);
        check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
        $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");

        foreach (rows[i]) begin
            if (!timed_out) begin
                apply_row(i, rows[i]);
            end
        end

        errors = errors + DUT.u_bus_arbiter.u_lsu_sva.sva_errors;
        $display("rows %0d of %0d, checks %0d, errors %0d", rows_run, rows.size(), checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
